//--- design/csam_defines.svh
`ifndef CSAM_DEFINES_SVH
`define CSAM_DEFINES_SVH

`default_nettype none

`define CSAM_WIDTH 16 // operand and rounded word width.
`define CSAM_PROD_WIDTH 32 // full product width.

// rounding window inside the product.
`define CSAM_ROUND_BIT 15
`define CSAM_STICKY_BIT 14

`default_nettype wire

`endif

//--- design/csamPkg.sv
`include "csam_defines.svh"
`default_nettype none

package csamPkg;

        typedef logic signed [`CSAM_WIDTH-1:0] operandT;

        typedef logic signed [`CSAM_PROD_WIDTH-1:0] productT;

        typedef logic signed [`CSAM_WIDTH-1:0] roundedT;

        // one carry-save row, bit 0 is the least significant weight of that row.
        typedef logic [`CSAM_WIDTH-1:0] csRowT;

        // row j holds the terms weighted by y[j].
        typedef csRowT [`CSAM_WIDTH-1:0] ppMatrixT;

endpackage

`default_nettype wire

//--- design/partialProductGen.sv
`timescale 1ns/10ps
`include "csam_defines.svh"
`default_nettype none

module partialProductGen (
        input csamPkg::operandT x,
        input csamPkg::operandT y,
        output csamPkg::ppMatrixT pp
);

        localparam int Msb = `CSAM_WIDTH - 1;

        always_comb begin
                for (int j = 0; j < `CSAM_WIDTH; j++) begin
                        for (int i = 0; i < `CSAM_WIDTH; i++) begin
                                // exactly one sign bit in the pair gives a negative weight.
                                if ((i == Msb) != (j == Msb)) begin
                                        pp[j][i] = ~(x[i] & y[j]);
                                end else begin
                                        pp[j][i] = x[i] & y[j]; // sign times sign stays positive.
                                end
                        end
                end
        end

endmodule

`default_nettype wire

//--- design/csaReduction.sv
`timescale 1ns/10ps
`include "csam_defines.svh"
`default_nettype none

module csaReduction (
        input logic clk,
        input logic rstN,
        input logic inValid,
        input csamPkg::ppMatrixT pp,
        output csamPkg::csRowT sumRow,
        output csamPkg::csRowT carryRow,
        output csamPkg::csRowT lowBits,
        output logic rowValid
);

        import csamPkg::*;

        localparam int Msb = `CSAM_WIDTH - 1;

        wire csRowT lowNext;

        assign lowNext[0] = pp[0][0]; // row 0 lsb needs no adder.

        genvar k;
        for (k = 1; k < `CSAM_WIDTH; k++) begin : rowGen
                wire csRowT addend;
                // after row k, sum bit i has weight i+k and carry bit i has weight i+k+1.
                wire csRowT rowSum;
                wire csRowT rowCarry;

                if (k == 1) begin : halfRow
                        // top cell is seeded with 1, adding the 2^16 correction.
                        assign addend = {1'b1, pp[0][Msb:1]};
                        assign rowSum = pp[k] ^ addend;
                        assign rowCarry = pp[k] & addend;
                end else begin : fullRow
                        assign addend = {1'b0, rowGen[k-1].rowSum[Msb:1]};
                        assign rowSum = pp[k] ^ addend ^ rowGen[k-1].rowCarry;
                        assign rowCarry = (pp[k] & addend) |
                                          (pp[k] & rowGen[k-1].rowCarry) |
                                          (addend & rowGen[k-1].rowCarry);
                end

                assign lowNext[k] = rowSum[0]; // each row retires one product bit.
        end

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        sumRow <= '0;
                        carryRow <= '0;
                        lowBits <= '0;
                        rowValid <= 1'b0;
                end else begin
                        sumRow <= rowGen[Msb].rowSum;
                        // top carry sits at weight 31, so flipping it adds the 2^31 correction.
                        carryRow <= {~rowGen[Msb].rowCarry[Msb], rowGen[Msb].rowCarry[Msb-1:0]};
                        lowBits <= lowNext;
                        rowValid <= inValid;
                end
        end

        rowValidKnown: assert property (
                @(posedge clk) disable iff (!rstN)
                !$isunknown(rowValid)
        );

endmodule

`default_nettype wire

//--- design/carryPropagateAdder.sv
`timescale 1ns/10ps
`include "csam_defines.svh"
`default_nettype none

module carryPropagateAdder (
        input logic clk,
        input logic rstN,
        input logic rowValid,
        input csamPkg::csRowT sumRow,
        input csamPkg::csRowT carryRow,
        input csamPkg::csRowT lowBits,
        output csamPkg::productT product,
        output logic productValid
);

        import csamPkg::*;

        csRowT shiftedSum;
        csRowT upperHalf;

        // sum bit 0 is already in lowBits, the rest lines up with weight 16.
        assign shiftedSum = {1'b0, sumRow[`CSAM_WIDTH-1:1]};

        always_comb begin : rippleChain
                logic ripple;

                ripple = 1'b0;
                for (int i = 0; i < `CSAM_WIDTH; i++) begin
                        upperHalf[i] = shiftedSum[i] ^ carryRow[i] ^ ripple;
                        ripple = (shiftedSum[i] & carryRow[i]) |
                                 (ripple & (shiftedSum[i] ^ carryRow[i]));
                end
                // carry out of bit 31 is dropped, the product is modulo 2^32.
        end

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        product <= '0;
                        productValid <= 1'b0;
                end else begin
                        product <= {upperHalf, lowBits};
                        productValid <= rowValid;
                end
        end

        productKnown: assert property (
                @(posedge clk) disable iff (!rstN)
                productValid |-> !$isunknown(product)
        );

endmodule

`default_nettype wire

//--- design/rneRounder.sv
`timescale 1ns/10ps
`include "csam_defines.svh"
`default_nettype none

module rneRounder (
        input logic clk,
        input logic rstN,
        input logic productValid,
        input csamPkg::productT product,
        output logic outValid,
        output csamPkg::productT productOut,
        output csamPkg::roundedT rounded
);

        import csamPkg::*;

        roundedT topWord;
        roundedT roundedNext;
        logic roundUp;

        assign topWord = product[`CSAM_PROD_WIDTH-1 -: `CSAM_WIDTH];

        // ties go to even, bits below the sticky bit are ignored.
        assign roundUp = product[`CSAM_ROUND_BIT] &
                         (product[`CSAM_STICKY_BIT] | product[`CSAM_ROUND_BIT+1]);

        // top word magnitude stays at or below 0x4000, so no wrap.
        assign roundedNext = topWord + roundedT'(roundUp);

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        outValid <= 1'b0;
                        productOut <= '0;
                        rounded <= '0;
                end else begin
                        outValid <= productValid;
                        productOut <= product;
                        rounded <= roundedNext;
                end
        end

        // the top word bound keeps the increment from flipping the sign.
        roundedNoWrap: assert property (
                @(posedge clk) disable iff (!rstN)
                outValid |-> (rounded == '0 ||
                              rounded[`CSAM_WIDTH-1] == productOut[`CSAM_PROD_WIDTH-1])
        );

endmodule

`default_nettype wire

//--- design/csam.sv
`timescale 1ns/10ps
`include "csam_defines.svh"
`default_nettype none

module csam (
        input logic clk,
        input logic rstN,
        input logic inValid,
        input logic signed [`CSAM_WIDTH-1:0] x,
        input logic signed [`CSAM_WIDTH-1:0] y,
        output logic outValid,
        output logic signed [`CSAM_PROD_WIDTH-1:0] product,
        output logic signed [`CSAM_WIDTH-1:0] rounded
);

        logic [`CSAM_WIDTH-1:0][`CSAM_WIDTH-1:0] pp;
        logic [`CSAM_WIDTH-1:0] sumRow;
        logic [`CSAM_WIDTH-1:0] carryRow;
        logic [`CSAM_WIDTH-1:0] lowBits;
        logic rowValid;
        logic signed [`CSAM_PROD_WIDTH-1:0] stageProduct;
        logic productValid;

        partialProductGen ppGen (
                .x(x),
                .y(y),
                .pp(pp)
        );

        // stage 1, carry-save rows.
        csaReduction reduction (
                .clk(clk),
                .rstN(rstN),
                .inValid(inValid),
                .pp(pp),
                .sumRow(sumRow),
                .carryRow(carryRow),
                .lowBits(lowBits),
                .rowValid(rowValid)
        );

        // stage 2, full product.
        carryPropagateAdder cpa (
                .clk(clk),
                .rstN(rstN),
                .rowValid(rowValid),
                .sumRow(sumRow),
                .carryRow(carryRow),
                .lowBits(lowBits),
                .product(stageProduct),
                .productValid(productValid)
        );

        // stage 3, rounded word.
        rneRounder rounder (
                .clk(clk),
                .rstN(rstN),
                .productValid(productValid),
                .product(stageProduct),
                .outValid(outValid),
                .productOut(product),
                .rounded(rounded)
        );

endmodule

`default_nettype wire

//--- tb/csamTb.sv
`timescale 1ns/10ps
`include "csam_defines.svh"
`default_nettype none

module csamTb;

        import csamPkg::*;

        localparam logic [31:0] LfsrSeed = 32'h4c91f2fb;
        localparam int RandomPairs = 2000;
        localparam int GatedPairs = 64;
        localparam int TimeoutCycles = 3000; // about 2100 cycles of tests plus margin.
        localparam operandT MinOp = 16'sh8000;
        localparam operandT MaxOp = 16'sh7fff;

        logic clk = 1'b0;
        logic rstN;
        logic inValid;
        operandT x;
        operandT y;
        logic outValid;
        productT product;
        roundedT rounded;

        logic [31:0] lfsrState = LfsrSeed;
        logic [2:0] validPipe = 3'b000; // inValid seen at the last three edges.
        productT productQueue[$];
        roundedT roundedQueue[$];
        int acceptedCount = 0;
        int pulseCount = 0;
        int cycleCount = 0;

        csam UUT (
                .clk(clk),
                .rstN(rstN),
                .inValid(inValid),
                .x(x),
                .y(y),
                .outValid(outValid),
                .product(product),
                .rounded(rounded)
        );

        initial begin
                forever #2 clk = ~clk;
        end

        // taps 32, 22, 2, 1.
        function automatic logic [31:0] lfsrNext(input logic [31:0] state);
                return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
        endfunction

        task automatic drawBits(input int count, output logic [15:0] bits);
                bits = '0;
                for (int i = 0; i < count; i++) begin
                        lfsrState = lfsrNext(lfsrState);
                        bits = {bits[14:0], lfsrState[0]};
                end
        endtask

        // exact signed product, then nearest-even on bits 31 to 14.
        function automatic void computeExpected(input operandT a, input operandT b,
                                                output productT expProduct,
                                                output roundedT expRounded);
                productT wideA;
                productT wideB;
                roundedT topWord;
                logic [1:0] fraction;

                wideA = a;
                wideB = b;
                expProduct = wideA * wideB;
                topWord = expProduct[`CSAM_PROD_WIDTH-1 -: `CSAM_WIDTH];
                fraction = expProduct[`CSAM_ROUND_BIT -: 2]; // quarters of one result lsb.
                if (fraction > 2'd2 || (fraction == 2'd2 && topWord[0])) begin
                        expRounded = topWord + roundedT'(1); // above half or a tie on an odd word.
                end else begin
                        expRounded = topWord;
                end
        endfunction

        task automatic failRun(input string reason);
                $display("%s", reason);
                $display("CHECKS FAILED");
                $fatal(1, "stopped at first error");
        endtask

        task automatic checkProduct(input string name, input productT expected,
                                    input productT actual);
                if (actual !== expected) begin
                        failRun($sformatf("Fail at %0t: %s expected %h got %h",
                                          $time, name, expected, actual));
                end
        endtask

        task automatic checkRounded(input string name, input roundedT expected,
                                    input roundedT actual);
                if (actual !== expected) begin
                        failRun($sformatf("Fail at %0t: %s expected %h got %h",
                                          $time, name, expected, actual));
                end
        endtask

        task automatic checkValid(input string name, input logic expected, input logic actual);
                if (actual !== expected) begin
                        failRun($sformatf("Fail at %0t: %s expected %b got %b",
                                          $time, name, expected, actual));
                end
        endtask

        task automatic checkCount(input string name, input int expected, input int actual);
                if (actual != expected) begin
                        failRun($sformatf("Fail at %0t: %s expected %0d got %0d",
                                          $time, name, expected, actual));
                end
        endtask

        task automatic drivePair(input operandT a, input operandT b, input logic valid);
                productT expProduct;
                roundedT expRounded;

                @(posedge clk);
                #1;
                x = a;
                y = b;
                inValid = valid;
                if (valid) begin
                        computeExpected(a, b, expProduct, expRounded);
                        productQueue.push_back(expProduct);
                        roundedQueue.push_back(expRounded);
                        acceptedCount++;
                end
        endtask

        task automatic drainAndCount();
                repeat (4) drivePair('0, '0, 1'b0); // three stages plus one spare cycle.
                checkCount("outValid pulses", acceptedCount, pulseCount);
        endtask

        always @(posedge clk) begin
                if (!rstN) begin
                        validPipe <= 3'b000;
                end else begin
                        validPipe <= {validPipe[1:0], inValid};
                end
        end

        always @(posedge clk) begin
                cycleCount++;
                if (cycleCount >= TimeoutCycles) begin
                        failRun("Timeout: the run did not finish within the cycle limit");
                end
        end

        // outputs settle after the rising edge, so they are sampled on the falling one.
        always @(negedge clk) begin
                productT expProduct;
                roundedT expRounded;

                checkValid("outValid", validPipe[2], outValid);
                if (outValid) begin
                        if (productQueue.size() == 0) begin
                                failRun("outValid pulsed with no input waiting for it");
                        end else begin
                                expProduct = productQueue.pop_front();
                                expRounded = roundedQueue.pop_front();
                                checkProduct("product", expProduct, product);
                                checkRounded("rounded", expRounded, rounded);
                                pulseCount++;
                        end
                end
        end

        initial begin
                operandT a;
                operandT b;
                logic [15:0] bits;

                rstN = 1'b0;
                inValid = 1'b0;
                x = '0;
                y = '0;
                repeat (3) @(posedge clk);
                #1;
                rstN = 1'b1;
                repeat (3) drivePair('0, '0, 1'b0); // idle, outValid must stay low.

                drivePair(16'sd0, 16'sd12345, 1'b1);
                drivePair(-16'sd4321, 16'sd0, 1'b1);
                drivePair(16'sd1, -16'sd1, 1'b1);
                drivePair(MinOp, MinOp, 1'b1); // 2^30, largest top word.
                drivePair(MinOp, MaxOp, 1'b1);
                drivePair(MaxOp, MaxOp, 1'b1);
                drivePair(16'sd1, MinOp, 1'b1); // tie with odd bit 16, rounds up to 0.
                drivePair(16'sh4000, 16'sd2, 1'b1); // tie with even bit 16, stays 0.
                drivePair(16'sh3000, 16'sd4, 1'b1); // sticky set, rounds up.
                drainAndCount();

                for (int i = 0; i < RandomPairs; i++) begin
                        drawBits(16, bits);
                        a = bits;
                        drawBits(16, bits);
                        b = bits;
                        drivePair(a, b, 1'b1);
                end
                drainAndCount();

                for (int i = 0; i < GatedPairs; i++) begin
                        drawBits(16, bits);
                        a = bits;
                        drawBits(16, bits);
                        b = bits;
                        drawBits(1, bits);
                        drivePair(a, b, bits[0]);
                end
                drainAndCount();

                $display("ALL CHECKS PASSED");
                $finish;
        end

endmodule

`default_nettype wire

//--- csam.f
+incdir+design
design/csamPkg.sv
design/partialProductGen.sv
design/csaReduction.sv
design/carryPropagateAdder.sv
design/rneRounder.sv
design/csam.sv
tb/csamTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f csam.f --top-module csamTb -o csamSim
output=$(./obj_dir/csamSim 2>&1 || true)
echo "$output"
if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
else
    exit 1
fi
